// File: verilog.f
src/comm_link_pkg.sv
src/link_assembler_out.sv
src/link_lane.sv
src/link_assembler_in.sv
src/link_calib_ctrl.sv
src/comm_link.sv
tests/tb_comm_link.sv

// File: Makefile
TOP = tb_comm_link

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: tests/tb_comm_link.sv
module tb_comm_link;
   import comm_link_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int DRIVE_DELAY = 10;
   localparam int RESET_CYCLES = 5;
   localparam int NUM_WORDS = 200;
   localparam int CYCLES_PER_WORD = 40;
   localparam int LONG_ACK_DELAY = 32;
   localparam int CREDITS_PER_TOKEN = 2;
   localparam int CALIB_BOUND = WAIT_AFTER_RESET_CYCLES + PREPARE_CYCLES + CALIB_TIMEOUT_CYCLES;
   // traffic run plus the corrupted run with one retry
   localparam int WATCHDOG_CYCLES = 3 * CALIB_BOUND + NUM_WORDS * CYCLES_PER_WORD;
   localparam int RAND_SEED = 32'hb3241f94;
   // flips every bit of the lane 0 slice, tag included
   localparam logic [CORE_WIDTH-1:0] CORRUPT_MASK = 32'h0000_00ff;

   logic                      io_master_clk_i;
   logic                      rst_n_i;
   logic                      core_req_i;
   logic [CORE_WIDTH-1:0]     core_data_i;
   logic                      core_ack_o;
   logic                      core_req_o;
   logic [CORE_WIDTH-1:0]     core_data_o;
   logic                      core_ack_i;
   logic [LINK_CHANNELS-1:0]  link_valid_o;
   logic [CORE_WIDTH-1:0]     link_data_o;
   logic [LINK_CHANNELS-1:0]  link_token_i;
   logic [LINK_CHANNELS-1:0]  link_valid_i;
   logic [CORE_WIDTH-1:0]     link_data_i;
   logic [LINK_CHANNELS-1:0]  link_token_o;
   logic                      link_prepare_o;
   logic                      calib_done_o;

   // loopback stages
   logic [LINK_CHANNELS-1:0]  valid_d1;
   logic [CORE_WIDTH-1:0]     data_d1;
   logic [LINK_CHANNELS-1:0]  token_d1;
   logic [LINK_CHANNELS-1:0]  valid_d2;
   logic [CORE_WIDTH-1:0]     data_d2;
   logic [LINK_CHANNELS-1:0]  token_d2;
   logic                      corrupt;

   // phase tracking from the top-level outputs
   logic                      seen_prepare;
   logic                      in_test;
   int                        prep_len;
   int                        outstanding [LINK_CHANNELS];
   logic [CORE_WIDTH-1:0]     prev_data_o;

   // scoreboard
   logic [CORE_WIDTH-1:0]     expected_q [$];
   int                        received;

   comm_link dut_i (.*);

   initial
   begin
      io_master_clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) io_master_clk_i = ~io_master_clk_i;
   end

   // **********************************************************************
   // reporting and small helpers
   // **********************************************************************

   task automatic end_with_failure();
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic report_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      $display("** Error at time %0t: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
      end_with_failure();
   endtask

   task automatic report_text(input string what);
      $display("Failure at time %0t: %s", $time, what);
      end_with_failure();
   endtask

   // inputs change a little after the rising edge
   task automatic wait_drive_slot();
      @(posedge io_master_clk_i);
      #DRIVE_DELAY;
   endtask

   task automatic offer_word(input logic [CORE_WIDTH-1:0] word);
      core_req_i  = 1'b1;
      core_data_i = word;
      expected_q.push_back(word);
   endtask

   // four-phase close, ack up, req down, ack down
   task automatic complete_word();
      while (!core_ack_o)
         wait_drive_slot();
      // req may linger a little while ack is already up
      repeat ($urandom % 3) wait_drive_slot();
      core_req_i  = 1'b0;
      // data is free once req is low
      core_data_i = $urandom;
      while (core_ack_o)
         wait_drive_slot();
   endtask

   task automatic wait_calibration(input int bound);
      int cycles;
      cycles = 0;
      while (!calib_done_o)
      begin
         wait_drive_slot();
         cycles++;
         assert (cycles <= bound)
         else
            report_text("calib_done_o did not rise within the calibration bound");
      end
   endtask

   task automatic wait_prepare_level(input logic level, input int bound, input string what);
      int cycles;
      cycles = 0;
      while (link_prepare_o != level)
      begin
         wait_drive_slot();
         cycles++;
         assert (cycles <= bound)
         else
            report_text(what);
      end
   endtask

   // **********************************************************************
   // link loopback, two register stages
   // **********************************************************************

   initial
   begin
      link_valid_i = '0;
      link_data_i  = '0;
      link_token_i = '0;
      valid_d1     = '0;
      data_d1      = '0;
      token_d1     = '0;
      valid_d2     = '0;
      data_d2      = '0;
      token_d2     = '0;
      forever
      begin
         wait_drive_slot();
         link_valid_i = valid_d2;
         link_data_i  = corrupt ? (data_d2 ^ CORRUPT_MASK) : data_d2;
         link_token_i = token_d2;
         valid_d2     = valid_d1;
         data_d2      = data_d1;
         token_d2     = token_d1;
         valid_d1     = link_valid_o;
         data_d1      = link_data_o;
         token_d1     = link_token_o;
      end
   end

   // **********************************************************************
   // core out consumer, short acks first, long stalls later
   // **********************************************************************

   initial
   begin
      int delay;
      logic [CORE_WIDTH-1:0] expected;
      core_ack_i = 1'b0;
      received   = 0;
      forever
      begin
         wait_drive_slot();
         if (core_req_o && !core_ack_i)
         begin
            assert (expected_q.size() > 0)
            else
               report_text("core_req_o raised with no word outstanding");
            expected = expected_q.pop_front();
            assert (core_data_o == expected)
            else
               report_value("core_data_o", expected, core_data_o);
            received++;
            // second half stalls long enough to fill the lane fifos
            if (received > NUM_WORDS / 2)
               delay = int'($urandom % LONG_ACK_DELAY);
            else
               delay = int'($urandom % 3);
            repeat (delay) wait_drive_slot();
            core_ack_i = 1'b1;
            while (core_req_o)
               wait_drive_slot();
            // ack may stay up a few cycles after req is gone
            repeat ($urandom % 3) wait_drive_slot();
            core_ack_i = 1'b0;
         end
      end
   end

   // **********************************************************************
   // trackers and assertions
   // **********************************************************************

   // test phase is the gap after prepare until done or the next prepare
   assign in_test = seen_prepare && !link_prepare_o && !calib_done_o;

   always @(posedge io_master_clk_i)
   begin
      prev_data_o <= core_data_o;
   end

   always @(posedge io_master_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         seen_prepare <= 1'b0;
         prep_len     <= 0;
         for (int i = 0; i < LINK_CHANNELS; i++)
            outstanding[i] <= 0;
      end
      else
      begin
         if (link_prepare_o)
            seen_prepare <= 1'b1;
         prep_len <= link_prepare_o ? prep_len + 1 : 0;
         // slices on the wire minus credits paid back by tokens
         if (calib_done_o)
         begin
            for (int i = 0; i < LINK_CHANNELS; i++)
               outstanding[i] <= outstanding[i] + int'(link_valid_o[i])
                                 - CREDITS_PER_TOKEN * int'(link_token_i[i]);
         end
      end
   end

   // link closed, nothing moves on the core ports or tokens
   assert property (@(posedge io_master_clk_i) disable iff (!rst_n_i)
      !calib_done_o |-> !core_ack_o && !core_req_o && (link_token_o == '0))
   else
      report_value("{core_ack_o, core_req_o, link_token_o}", 32'd0,
                   32'($sampled({core_ack_o, core_req_o, link_token_o})));

   // only test words leave before the link opens
   assert property (@(posedge io_master_clk_i) disable iff (!rst_n_i)
      !calib_done_o && !in_test |-> link_valid_o == '0)
   else
      report_value("link_valid_o", 32'd0, 32'($sampled(link_valid_o)));

   assert property (@(posedge io_master_clk_i) disable iff (!rst_n_i)
      $fell(link_prepare_o) |-> prep_len == PREPARE_CYCLES)
   else
      report_value("link_prepare_o length", PREPARE_CYCLES, $sampled(prep_len));

   // a corrupted lane never lets the link open
   assert property (@(posedge io_master_clk_i) disable iff (!rst_n_i)
      corrupt |-> !calib_done_o)
   else
      report_value("calib_done_o", 32'd0, 32'($sampled(calib_done_o)));

   // core in, ack only answers a pending req
   assert property (@(posedge io_master_clk_i) disable iff (!rst_n_i)
      !core_req_i && !core_ack_o |=> !core_ack_o)
   else
      report_value("core_ack_o", 32'd0, 32'($sampled(core_ack_o)));

   // core in, ack holds until req is seen low
   assert property (@(posedge io_master_clk_i) disable iff (!rst_n_i)
      core_req_i && core_ack_o |=> core_ack_o)
   else
      report_value("core_ack_o", 32'd1, 32'($sampled(core_ack_o)));

   // core out, req holds until ack
   assert property (@(posedge io_master_clk_i) disable iff (!rst_n_i)
      core_req_o && !core_ack_i |=> core_req_o)
   else
      report_value("core_req_o", 32'd1, 32'($sampled(core_req_o)));

   // core out, no new word while ack is still high
   assert property (@(posedge io_master_clk_i) disable iff (!rst_n_i)
      core_ack_i |=> !$rose(core_req_o))
   else
      report_value("core_req_o", 32'd0, 32'($sampled(core_req_o)));

   assert property (@(posedge io_master_clk_i) disable iff (!rst_n_i)
      core_req_o && !$rose(core_req_o) |-> core_data_o == prev_data_o)
   else
      report_value("core_data_o", $sampled(prev_data_o), $sampled(core_data_o));

   for (genvar g = 0; g < LINK_CHANNELS; g++)
   begin : g_lane_check
      // tag sits on top of every test word
      assert property (@(posedge io_master_clk_i) disable iff (!rst_n_i)
         in_test && link_valid_o[g]
         |-> link_data_o[g*CHANNEL_WIDTH + SEQ_WIDTH +: TAG_WIDTH] == CALIB_TAG)
      else
         report_value($sformatf("link_data_o tag of lane %0d", g), 32'(CALIB_TAG),
            32'($sampled(link_data_o[g*CHANNEL_WIDTH + SEQ_WIDTH +: TAG_WIDTH])));

      assert property (@(posedge io_master_clk_i) disable iff (!rst_n_i)
         outstanding[g] <= START_CREDITS)
      else
         report_value($sformatf("credits in flight on lane %0d", g), START_CREDITS,
                      $sampled(outstanding[g]));
   end

   // **********************************************************************
   // main sequence
   // **********************************************************************

   initial
   begin
      void'($urandom(RAND_SEED));
      rst_n_i     = 1'b0;
      core_req_i  = 1'b0;
      core_data_i = '0;
      corrupt     = 1'b0;
      repeat (RESET_CYCLES) @(posedge io_master_clk_i);
      #DRIVE_DELAY;
      rst_n_i = 1'b1;

      // first word waits on the closed link
      offer_word($urandom);
      wait_calibration(CALIB_BOUND);
      complete_word();
      for (int n = 1; n < NUM_WORDS; n++)
      begin
         repeat ($urandom % 3) wait_drive_slot();
         offer_word($urandom);
         complete_word();
      end

      // drain the link
      while (received < NUM_WORDS)
         wait_drive_slot();
      while (core_req_o)
         wait_drive_slot();
      repeat (2) wait_drive_slot();
      assert (expected_q.size() == 0)
      else
         report_value("words left in the queue", 32'd0, 32'(expected_q.size()));

      // second run, lane 0 corrupted on the way back
      rst_n_i = 1'b0;
      corrupt = 1'b1;
      repeat (RESET_CYCLES) wait_drive_slot();
      rst_n_i = 1'b1;
      wait_prepare_level(1'b1, WAIT_AFTER_RESET_CYCLES + 2,
                         "link_prepare_o did not rise after reset");
      wait_prepare_level(1'b0, PREPARE_CYCLES + 2, "link_prepare_o did not fall");
      wait_prepare_level(1'b1, CALIB_TIMEOUT_CYCLES + 2,
                         "link_prepare_o did not rise again for the retry");
      assert (!calib_done_o)
      else
         report_value("calib_done_o", 32'd0, 32'(calib_done_o));

      $display("Simulation PASSED");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      report_text("watchdog expired, the run stopped making progress");
   end

endmodule

// File: src/comm_link.sv
module comm_link
(
     input  logic                                     io_master_clk_i
   , input  logic                                     rst_n_i
   // core in, four-phase
   , input  logic                                     core_req_i
   , input  logic [comm_link_pkg::CORE_WIDTH-1:0]     core_data_i
   , output logic                                     core_ack_o
   // core out, four-phase
   , output logic                                     core_req_o
   , output logic [comm_link_pkg::CORE_WIDTH-1:0]     core_data_o
   , input  logic                                     core_ack_i
   // outgoing link
   , output logic [comm_link_pkg::LINK_CHANNELS-1:0]  link_valid_o
   , output logic [comm_link_pkg::CORE_WIDTH-1:0]     link_data_o
   , input  logic [comm_link_pkg::LINK_CHANNELS-1:0]  link_token_i
   // incoming link
   , input  logic [comm_link_pkg::LINK_CHANNELS-1:0]  link_valid_i
   , input  logic [comm_link_pkg::CORE_WIDTH-1:0]     link_data_i
   , output logic [comm_link_pkg::LINK_CHANNELS-1:0]  link_token_o
   // calibration status
   , output logic                                     link_prepare_o
   , output logic                                     calib_done_o
);
   import comm_link_pkg::*;

   // assembler-out to lanes
   logic [LINK_CHANNELS-1:0]        slice_valid;
   logic [LINK_CHANNELS-1:0]        slice_ready;
   link_word_u [LINK_CHANNELS-1:0]  slice_data;

   // lanes to assembler-in
   logic [LINK_CHANNELS-1:0]        rx_valid;
   logic [LINK_CHANNELS-1:0]        rx_pop;
   link_word_u [LINK_CHANNELS-1:0]  rx_data;

   // calibration
   logic [LINK_CHANNELS-1:0]        lane_pass;
   calib_state_e                    calib_phase;

   link_assembler_out u_asm_out
   (
        .io_master_clk_i (io_master_clk_i)
      , .rst_n_i         (rst_n_i)
      , .core_req_i      (core_req_i)
      , .core_data_i     (core_data_i)
      , .core_ack_o      (core_ack_o)
      , .slice_ready_i   (slice_ready)
      , .slice_valid_o   (slice_valid)
      , .slice_data_o    (slice_data)
   );

   // **********************************************************************
   // one lane per link channel
   // **********************************************************************

   for (genvar i = 0; i < LINK_CHANNELS; i++)
   begin : g_lane
      link_lane u_lane
      (
           .io_master_clk_i (io_master_clk_i)
         , .rst_n_i         (rst_n_i)
         , .calib_phase_i   (calib_phase)
         , .slice_valid_i   (slice_valid[i])
         , .slice_data_i    (slice_data[i])
         , .slice_ready_o   (slice_ready[i])
         , .link_valid_o    (link_valid_o[i])
         , .link_data_o     (link_data_o[i*CHANNEL_WIDTH +: CHANNEL_WIDTH])
         , .link_token_i    (link_token_i[i])
         , .link_valid_i    (link_valid_i[i])
         , .link_data_i     (link_data_i[i*CHANNEL_WIDTH +: CHANNEL_WIDTH])
         , .link_token_o    (link_token_o[i])
         , .rx_pop_i        (rx_pop[i])
         , .rx_valid_o      (rx_valid[i])
         , .rx_data_o       (rx_data[i])
         , .lane_pass_o     (lane_pass[i])
      );
   end

   link_assembler_in u_asm_in
   (
        .io_master_clk_i (io_master_clk_i)
      , .rst_n_i         (rst_n_i)
      , .rx_valid_i      (rx_valid)
      , .rx_data_i       (rx_data)
      , .rx_pop_o        (rx_pop)
      , .core_req_o      (core_req_o)
      , .core_data_o     (core_data_o)
      , .core_ack_i      (core_ack_i)
   );

   // phase output doubles as the lane mode
   link_calib_ctrl u_calib_ctrl
   (
        .io_master_clk_i (io_master_clk_i)
      , .rst_n_i         (rst_n_i)
      , .lane_pass_i     (lane_pass)
      , .calib_phase_o   (calib_phase)
      , .link_prepare_o  (link_prepare_o)
      , .calib_done_o    (calib_done_o)
   );

endmodule

// File: src/link_calib_ctrl.sv
module link_calib_ctrl
(
     input  logic                                     io_master_clk_i
   , input  logic                                     rst_n_i
   // one pass flag per lane
   , input  logic [comm_link_pkg::LINK_CHANNELS-1:0]  lane_pass_i
   // shared lane mode
   , output comm_link_pkg::calib_state_e              calib_phase_o
   , output logic                                     link_prepare_o
   , output logic                                     calib_done_o
);
   import comm_link_pkg::*;

   logic [CTRL_CNT_WIDTH-1:0] cnt_r;

   assign link_prepare_o = (calib_phase_o == PREPARE);
   assign calib_done_o   = (calib_phase_o == DONE);

   // **********************************************************************
   // wait, prepare, test, then done or retry
   // **********************************************************************

   always_ff @(posedge io_master_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         calib_phase_o <= WAIT;
         cnt_r         <= '0;
      end
      else
      begin
         cnt_r <= cnt_r + 1'b1;
         case (calib_phase_o)
            WAIT:
            begin
               // quiet period after reset
               if (cnt_r == CTRL_CNT_WIDTH'(WAIT_AFTER_RESET_CYCLES - 1))
               begin
                  calib_phase_o <= PREPARE;
                  cnt_r         <= '0;
               end
            end
            PREPARE:
            begin
               // lanes clear fifos, checkers and refill credits
               if (cnt_r == CTRL_CNT_WIDTH'(PREPARE_CYCLES - 1))
               begin
                  calib_phase_o <= TEST;
                  cnt_r         <= '0;
               end
            end
            TEST:
            begin
               if (&lane_pass_i)
               begin
                  calib_phase_o <= DONE;
               end
               else if (cnt_r == CTRL_CNT_WIDTH'(CALIB_TIMEOUT_CYCLES - 1))
               begin
                  // some lane never saw its sequence, go again
                  calib_phase_o <= PREPARE;
                  cnt_r         <= '0;
               end
            end
            default:
            begin
               // link open until reset
               cnt_r <= cnt_r;
            end
         endcase
      end
   end

endmodule

// File: src/link_assembler_in.sv
module link_assembler_in
(
     input  logic                                     io_master_clk_i
   , input  logic                                     rst_n_i
   // from the lane fifos
   , input  logic [comm_link_pkg::LINK_CHANNELS-1:0]  rx_valid_i
   , input  comm_link_pkg::link_word_u [comm_link_pkg::LINK_CHANNELS-1:0] rx_data_i
   , output logic [comm_link_pkg::LINK_CHANNELS-1:0]  rx_pop_o
   // four-phase core port
   , output logic                                     core_req_o
   , output logic [comm_link_pkg::CORE_WIDTH-1:0]     core_data_o
   , input  logic                                     core_ack_i
);
   import comm_link_pkg::*;

   logic word_pop;

   // register is free once req and ack are both back low
   // every lane must have its slice
   assign word_pop = (&rx_valid_i) & ~core_req_o & ~core_ack_i;
   assign rx_pop_o = {LINK_CHANNELS{word_pop}};

   // payload register, loaded in lane order
   always_ff @(posedge io_master_clk_i)
   begin
      if (word_pop)
      begin
         for (int i = 0; i < LINK_CHANNELS; i++)
         begin
            core_data_o[i*CHANNEL_WIDTH +: CHANNEL_WIDTH] <= rx_data_i[i].data;
         end
      end
   end

   // **********************************************************************
   // output handshake
   // **********************************************************************

   // req rises after the pop, drops when ack is seen
   always_ff @(posedge io_master_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         core_req_o <= 1'b0;
      end
      else if (word_pop)
      begin
         core_req_o <= 1'b1;
      end
      else if (core_ack_i)
      begin
         core_req_o <= 1'b0;
      end
   end

endmodule

// File: src/link_lane.sv
module link_lane
(
     input  logic                        io_master_clk_i
   , input  logic                        rst_n_i
   // lane mode from the controller
   , input  comm_link_pkg::calib_state_e calib_phase_i
   // from the assembler-out
   , input  logic                        slice_valid_i
   , input  comm_link_pkg::link_word_u   slice_data_i
   , output logic                        slice_ready_o
   // outgoing link
   , output logic                        link_valid_o
   , output comm_link_pkg::link_word_u   link_data_o
   , input  logic                        link_token_i
   // incoming link
   , input  logic                        link_valid_i
   , input  comm_link_pkg::link_word_u   link_data_i
   , output logic                        link_token_o
   // toward the assembler-in
   , input  logic                        rx_pop_i
   , output logic                        rx_valid_o
   , output comm_link_pkg::link_word_u   rx_data_o
   // to the controller
   , output logic                        lane_pass_o
);
   import comm_link_pkg::*;

   logic [CREDIT_WIDTH-1:0]  credit_r;
   logic [CREDIT_WIDTH-1:0]  token_credits;
   logic                     slice_move;
   logic [SEQ_WIDTH-1:0]     tx_cnt_r;
   link_word_u               calib_word;

   link_word_u               fifo_mem [0:(1 << LG_FIFO_DEPTH)-1];
   logic [LG_FIFO_DEPTH:0]   wr_ptr_r;
   logic [LG_FIFO_DEPTH:0]   rd_ptr_r;
   logic                     fifo_wr;
   logic [LG_CREDIT_TO_TOKEN-1:0] pop_cnt_r;
   logic [SEQ_WIDTH-1:0]     chk_cnt_r;

   // **********************************************************************
   // transmit side
   // **********************************************************************

   // data only moves once the link is open and the far fifo has room
   assign slice_ready_o = (calib_phase_i == DONE) && (credit_r != '0);
   assign slice_move    = slice_valid_i & slice_ready_o;
   assign token_credits = link_token_i ? CREDIT_WIDTH'(1 << LG_CREDIT_TO_TOKEN) : '0;

   // prepare refills, a move spends one, a token pays back two
   always_ff @(posedge io_master_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         credit_r <= '0;
      end
      else if (calib_phase_i == PREPARE)
      begin
         credit_r <= CREDIT_WIDTH'(START_CREDITS);
      end
      else
      begin
         credit_r <= credit_r + token_credits - CREDIT_WIDTH'(slice_move);
      end
   end

   // numbered test word, tag fixed
   always_comb
   begin
      calib_word.calib.tag = CALIB_TAG;
      calib_word.calib.seq = tx_cnt_r;
   end

   // test words go out back to back, one burst per attempt
   always_ff @(posedge io_master_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         tx_cnt_r     <= '0;
         link_valid_o <= 1'b0;
      end
      else
      begin
         link_valid_o <= 1'b0;
         case (calib_phase_i)
            PREPARE:
            begin
               tx_cnt_r <= '0;
            end
            TEST:
            begin
               if (tx_cnt_r < SEQ_WIDTH'(CALIB_WORDS))
               begin
                  link_valid_o <= 1'b1;
                  tx_cnt_r     <= tx_cnt_r + 1'b1;
               end
            end
            DONE:
            begin
               link_valid_o <= slice_move;
            end
            default:
            begin
            end
         endcase
      end
   end

   // output data register, no credit is spent in test
   always_ff @(posedge io_master_clk_i)
   begin
      link_data_o <= (calib_phase_i == TEST) ? calib_word : slice_data_i;
   end

   // **********************************************************************
   // receive side
   // **********************************************************************

   // fifo is written in the arrival cycle
   assign fifo_wr    = link_valid_i && (calib_phase_i == DONE);
   assign rx_valid_o = (wr_ptr_r != rd_ptr_r);
   assign rx_data_o  = fifo_mem[rd_ptr_r[LG_FIFO_DEPTH-1:0]];

   always_ff @(posedge io_master_clk_i)
   begin
      if (fifo_wr)
      begin
         fifo_mem[wr_ptr_r[LG_FIFO_DEPTH-1:0]] <= link_data_i;
      end
   end

   // pointers and token return, one pulse per two pops
   always_ff @(posedge io_master_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_r     <= '0;
         rd_ptr_r     <= '0;
         pop_cnt_r    <= '0;
         link_token_o <= 1'b0;
      end
      else if (calib_phase_i == PREPARE)
      begin
         wr_ptr_r     <= '0;
         rd_ptr_r     <= '0;
         pop_cnt_r    <= '0;
         link_token_o <= 1'b0;
      end
      else
      begin
         if (fifo_wr)
         begin
            wr_ptr_r <= wr_ptr_r + 1'b1;
         end
         if (rx_pop_i)
         begin
            rd_ptr_r  <= rd_ptr_r + 1'b1;
            pop_cnt_r <= pop_cnt_r + 1'b1;
         end
         link_token_o <= rx_pop_i & (&pop_cnt_r);
      end
   end

   // checker counts in-order test words, any miss starts over
   always_ff @(posedge io_master_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         chk_cnt_r   <= '0;
         lane_pass_o <= 1'b0;
      end
      else if (calib_phase_i == PREPARE)
      begin
         chk_cnt_r   <= '0;
         lane_pass_o <= 1'b0;
      end
      else if (link_valid_i && (calib_phase_i == TEST))
      begin
         if ((link_data_i.calib.tag == CALIB_TAG) && (link_data_i.calib.seq == chk_cnt_r))
         begin
            chk_cnt_r <= chk_cnt_r + 1'b1;
            // last word of the sequence
            if (chk_cnt_r == SEQ_WIDTH'(CALIB_WORDS - 1))
            begin
               lane_pass_o <= 1'b1;
            end
         end
         else
         begin
            chk_cnt_r <= '0;
         end
      end
   end

endmodule

// File: src/link_assembler_out.sv
module link_assembler_out
(
     input  logic                                     io_master_clk_i
   , input  logic                                     rst_n_i
   // four-phase core port
   , input  logic                                     core_req_i
   , input  logic [comm_link_pkg::CORE_WIDTH-1:0]     core_data_i
   , output logic                                     core_ack_o
   // toward the lanes
   , input  logic [comm_link_pkg::LINK_CHANNELS-1:0]  slice_ready_i
   , output logic [comm_link_pkg::LINK_CHANNELS-1:0]  slice_valid_o
   , output comm_link_pkg::link_word_u [comm_link_pkg::LINK_CHANNELS-1:0] slice_data_o
);
   import comm_link_pkg::*;

   logic slice_move;

   // accept window is req high with ack still low
   // all lanes move together or none does
   assign slice_move    = core_req_i & ~core_ack_o & (&slice_ready_i);
   assign slice_valid_o = {LINK_CHANNELS{slice_move}};

   // lane i carries bits i*8 up to i*8+7
   always_comb
   begin
      for (int i = 0; i < LINK_CHANNELS; i++)
      begin
         slice_data_o[i].data = core_data_i[i*CHANNEL_WIDTH +: CHANNEL_WIDTH];
      end
   end

   // **********************************************************************
   // handshake state
   // **********************************************************************

   // ack low means waiting for a word
   // ack high means word taken, waiting for req to drop
   always_ff @(posedge io_master_clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         core_ack_o <= 1'b0;
      end
      else if (slice_move)
      begin
         // slices went out this cycle
         core_ack_o <= 1'b1;
      end
      else if (!core_req_i)
      begin
         // req seen low, close the cycle
         core_ack_o <= 1'b0;
      end
   end

endmodule

// File: src/comm_link_pkg.sv
package comm_link_pkg;

   // **********************************************************************
   // link geometry
   // **********************************************************************

   // bits carried by one lane per cycle
   localparam int CHANNEL_WIDTH = 8;
   localparam int LINK_CHANNELS = 4;
   // one core word is spread over every lane
   localparam int CORE_WIDTH = CHANNEL_WIDTH * LINK_CHANNELS;

   // receive fifo per lane, 8 slots
   localparam int LG_FIFO_DEPTH = 3;
   // far end can take a full fifo right after prepare
   localparam int START_CREDITS = 1 << LG_FIFO_DEPTH;
   // one token pulse stands for 2 freed slots
   localparam int LG_CREDIT_TO_TOKEN = 1;
   // counter has to hold START_CREDITS itself
   localparam int CREDIT_WIDTH = $clog2(START_CREDITS + 1);

   // **********************************************************************
   // calibration
   // **********************************************************************

   localparam int WAIT_AFTER_RESET_CYCLES = 16;
   localparam int PREPARE_CYCLES = 20;
   // test words sent by every lane per attempt
   localparam int CALIB_WORDS = 16;
   localparam int CALIB_TIMEOUT_CYCLES = 200;
   // wide enough for the longest phase
   localparam int CTRL_CNT_WIDTH = $clog2(CALIB_TIMEOUT_CYCLES);

   // test word layout, marker on top and sequence below
   localparam int TAG_WIDTH = 3;
   localparam int SEQ_WIDTH = CHANNEL_WIDTH - TAG_WIDTH;
   localparam logic [TAG_WIDTH-1:0] CALIB_TAG = 3'b101;

   // one lane slice, raw data or test word
   typedef union packed
   {
      logic [CHANNEL_WIDTH-1:0] data;
      struct packed
      {
         logic [TAG_WIDTH-1:0] tag;
         logic [SEQ_WIDTH-1:0] seq;
      } calib;
   } link_word_u;

   // link phase, also the lane mode
   typedef enum logic [1:0]
   {
      WAIT,
      PREPARE,
      TEST,
      DONE
   } calib_state_e;

endpackage
